// File: hw/cmp_pkg.sv
// Shared widths, instruction fields, opcodes and condition-byte layout for the compare unit
`default_nettype none

package cmp_pkg;

	// ======================================================================
	// Datapath widths
	// ======================================================================

	// Operands and the condition register share one width
	localparam int DATA_W = 32;
	// Instruction word width
	localparam int INSN_W = 32;
	// The operating mode picks one of four condition-byte lanes
	localparam int MODE_W = 2;
	// One condition byte per lane
	localparam int LANE_W = 8;

	// Single-precision field layout used by the FP comparator
	localparam int FP_EXP_LSB = 23;
	localparam int FP_EXP_W   = 8;
	localparam int FP_MAN_W   = 23;

	// ======================================================================
	// Instruction fields and codes
	// ======================================================================

	// Opcode sits in the low bits of the instruction
	localparam int OPC_LSB = 0;
	localparam int OPC_W   = 7;
	// The two-bit op2 field follows the opcode
	localparam int OP2_LSB = 7;
	localparam int OP2_W   = 2;
	// Top bit set means the second operand comes from the immediate
	localparam int IMM_BIT = 31;

	localparam logic [OPC_W-1:0] OP_CMP = 7'h0C;

	// Compare forms carried in op2, code 3 has no meaning and yields a zero byte
	localparam logic [OP2_W-1:0] OP2_CMP  = 2'd0;
	localparam logic [OP2_W-1:0] OP2_CMPA = 2'd1;
	localparam logic [OP2_W-1:0] OP2_FCMP = 2'd2;

	// ======================================================================
	// Condition byte bit positions
	// ======================================================================

	localparam int CB_EQ   = 0;
	localparam int CB_NAND = 1;
	localparam int CB_NOR  = 2;
	localparam int CB_LT   = 3;
	localparam int CB_LE   = 4;
	localparam int CB_CA   = 5;
	localparam int CB_SO   = 6;
	localparam int CB_RESV = 7;

	// Source of the flags that go into the condition byte
	typedef enum logic [1:0] {
		RES_ZERO = 2'd0,
		RES_INT  = 2'd1,
		RES_FP   = 2'd2
	} res_sel_t;

endpackage : cmp_pkg

`default_nettype wire

// File: hw/cmp_decode.sv
// Instruction decoder and issue register feeding the comparators and the condition register
`default_nettype none

module cmp_decode
	import cmp_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              issue,
	input  logic [INSN_W-1:0] ir,
	input  logic [MODE_W-1:0] om,
	input  logic [DATA_W-1:0] a,
	input  logic [DATA_W-1:0] b,
	input  logic [DATA_W-1:0] imm,
	output logic [DATA_W-1:0] op_a,
	output logic [DATA_W-1:0] op_b,
	output logic              is_signed,
	output res_sel_t          res_sel,
	output logic              imm_form,
	output logic [MODE_W-1:0] lane,
	output logic              valid
);

	logic [OPC_W-1:0] opcode;
	logic [OP2_W-1:0] op2;
	logic             dec_imm;
	logic             dec_signed;
	res_sel_t         dec_sel;

	// ======================================================================
	// Field extraction and decode
	// ======================================================================

	assign opcode  = ir[OPC_LSB +: OPC_W];
	assign op2     = ir[OP2_LSB +: OP2_W];
	assign dec_imm = ir[IMM_BIT];

	// Only the plain compare form treats operands as two's complement
	assign dec_signed = (op2 == OP2_CMP);

	always_comb
	begin
		dec_sel = RES_ZERO;
		if (opcode == OP_CMP)
		begin
			case (op2)
				OP2_CMP, OP2_CMPA:
					dec_sel = RES_INT;
				OP2_FCMP:
					dec_sel = RES_FP;
				// The spare op2 code leaves a cleared lane behind
				default:
					dec_sel = RES_ZERO;
			endcase
		end
	end

	// ======================================================================
	// Execute stage register
	// ======================================================================

	// Valid marks a stage that holds a compare waiting to be merged
	always_ff @(posedge clk)
	begin
		if (rst)
			valid <= 1'b0;
		else
			valid <= issue;
	end

	// Operands and decoded controls are loaded on each issue
	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			op_a      <= a;
			op_b      <= dec_imm ? imm : b;
			is_signed <= dec_signed;
			res_sel   <= dec_sel;
			imm_form  <= dec_imm;
			lane      <= om;
		end
	end

	// An instruction with unknown bits would corrupt the decoded lane contents
	a_ir_known : assert property (@(posedge clk) disable iff (rst)
		issue |-> !$isunknown(ir));

endmodule : cmp_decode

`default_nettype wire

// File: hw/int_compare.sv
// Integer comparator giving the condition flags for signed or unsigned operand pairs
`default_nettype none

module int_compare
	import cmp_pkg::*;
(
	input  logic [DATA_W-1:0] op_a,
	input  logic [DATA_W-1:0] op_b,
	input  logic              is_signed,
	output logic              eq,
	output logic              lt,
	output logic              le,
	output logic              ca,
	output logic              nand_f,
	output logic              nor_f
);

	// One extra bit on top of the difference catches the borrow
	logic [DATA_W:0] diff;
	logic            borrow;
	logic            sign_a;
	logic            sign_b;

	// ======================================================================
	// Subtractor and ordering
	// ======================================================================

	assign diff   = {1'b0, op_a} - {1'b0, op_b};
	assign borrow = diff[DATA_W];

	assign sign_a = op_a[DATA_W-1];
	assign sign_b = op_b[DATA_W-1];

	// With equal signs the unsigned borrow already orders signed values
	// When the signs differ in a signed compare the negative one is smaller
	assign lt = (is_signed && (sign_a != sign_b)) ? sign_a : borrow;

	assign eq = (op_a == op_b);
	assign le = lt | eq;

	// Carry is always the unsigned borrow, whatever the signedness
	assign ca = borrow;

	// ======================================================================
	// Bitwise reduction flags
	// ======================================================================

	// Set when the operands share no set bit
	assign nand_f = ~|(op_a & op_b);
	// Set only when both operands are entirely zero
	assign nor_f  = ~|(op_a | op_b);

endmodule : int_compare

`default_nettype wire

// File: hw/fp_compare.sv
// Single-precision comparator giving order, infinity and NaN flags for one operand pair
`default_nettype none

module fp_compare
	import cmp_pkg::*;
(
	input  logic [DATA_W-1:0] op_a,
	input  logic [DATA_W-1:0] op_b,
	output logic              eq,
	output logic              lt,
	output logic              le,
	output logic              inf,
	output logic              nan
);

	logic                sign_a;
	logic                sign_b;
	logic [FP_EXP_W-1:0] exp_a;
	logic [FP_EXP_W-1:0] exp_b;
	logic [FP_MAN_W-1:0] man_a;
	logic [FP_MAN_W-1:0] man_b;
	// Magnitude is everything below the sign bit
	logic [DATA_W-2:0]   mag_a;
	logic [DATA_W-2:0]   mag_b;
	logic                nan_a;
	logic                nan_b;
	logic                inf_a;
	logic                inf_b;
	logic                both_zero;
	logic                ordered_lt;

	// ======================================================================
	// Field decode
	// ======================================================================

	assign sign_a = op_a[DATA_W-1];
	assign sign_b = op_b[DATA_W-1];
	assign exp_a  = op_a[FP_EXP_LSB +: FP_EXP_W];
	assign exp_b  = op_b[FP_EXP_LSB +: FP_EXP_W];
	assign man_a  = op_a[FP_MAN_W-1:0];
	assign man_b  = op_b[FP_MAN_W-1:0];
	assign mag_a  = op_a[DATA_W-2:0];
	assign mag_b  = op_b[DATA_W-2:0];

	// All-ones exponent is a NaN with a nonzero mantissa, infinity otherwise
	assign nan_a = (&exp_a) & (|man_a);
	assign nan_b = (&exp_b) & (|man_b);
	assign inf_a = (&exp_a) & ~(|man_a);
	assign inf_b = (&exp_b) & ~(|man_b);

	assign nan = nan_a | nan_b;
	assign inf = inf_a | inf_b;

	// Plus and minus zero differ only in the sign bit
	assign both_zero = ~(|mag_a) & ~(|mag_b);

	// ======================================================================
	// Ordering
	// ======================================================================

	always_comb
	begin
		if (both_zero)
			ordered_lt = 1'b0;
		else if (sign_a != sign_b)
			ordered_lt = sign_a;
		else if (!sign_a)
			ordered_lt = (mag_a < mag_b);
		// Both negative, so the larger magnitude is the smaller value
		else
			ordered_lt = (mag_a > mag_b);
	end

	// An unordered pair reports neither equal nor less
	assign eq = ~nan & ((op_a == op_b) | both_zero);
	assign lt = ~nan & ordered_lt;
	assign le = lt | eq;

endmodule : fp_compare

`default_nettype wire

// File: hw/cond_reg_update.sv
// Condition register that merges each new condition byte into the lane chosen by the mode
`default_nettype none

module cond_reg_update
	import cmp_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              valid,
	input  logic [MODE_W-1:0] lane,
	input  res_sel_t          res_sel,
	input  logic              imm_form,
	input  logic              int_eq,
	input  logic              int_lt,
	input  logic              int_le,
	input  logic              int_ca,
	input  logic              int_nand,
	input  logic              int_nor,
	input  logic              fp_eq,
	input  logic              fp_lt,
	input  logic              fp_le,
	input  logic              fp_inf,
	input  logic              fp_nan,
	output logic [DATA_W-1:0] cr,
	output logic              done
);

	// Bit offset of the lane inside the register
	logic [MODE_W+$clog2(LANE_W)-1:0] shift;
	logic [LANE_W-1:0]                old_cb;
	logic [LANE_W-1:0]                new_cb;
	logic [DATA_W-1:0]                lane_mask;
	logic [DATA_W-1:0]                cr_next;

	assign shift  = {lane, {$clog2(LANE_W){1'b0}}};
	// The lane is read from the live register so a compare right behind sees it
	assign old_cb = cr[shift +: LANE_W];

	// ======================================================================
	// Condition byte assembly
	// ======================================================================

	always_comb
	begin
		new_cb = '0;
		case (res_sel)
			RES_INT:
			begin
				new_cb[CB_EQ]   = int_eq;
				new_cb[CB_NAND] = int_nand;
				new_cb[CB_NOR]  = int_nor;
				new_cb[CB_LT]   = int_lt;
				new_cb[CB_LE]   = int_le;
				new_cb[CB_CA]   = int_ca;
				new_cb[CB_SO]   = old_cb[CB_SO];
				// Register form clears the reserved bit
				new_cb[CB_RESV] = imm_form & old_cb[CB_RESV];
			end
			RES_FP:
			begin
				new_cb[CB_EQ]   = fp_eq;
				// Bitwise flags are shared with the integer path
				new_cb[CB_NAND] = int_nand;
				new_cb[CB_NOR]  = int_nor;
				new_cb[CB_LT]   = fp_lt;
				new_cb[CB_LE]   = fp_le;
				new_cb[CB_CA]   = fp_inf;
				// Summary overflow is sticky once a NaN has been seen
				new_cb[CB_SO]   = old_cb[CB_SO] | fp_nan;
				new_cb[CB_RESV] = imm_form ? old_cb[CB_RESV] : fp_nan;
			end
			default:
				new_cb = '0;
		endcase
	end

	// ======================================================================
	// Lane merge and register
	// ======================================================================

	assign lane_mask = DATA_W'({LANE_W{1'b1}}) << shift;
	assign cr_next   = (cr & ~lane_mask) | (DATA_W'(new_cb) << shift);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cr   <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= valid;
			if (valid)
				cr <= cr_next;
		end
	end

	// A staged compare carries a known lane and one of the three result sources
	a_stage_known : assert property (@(posedge clk) disable iff (rst)
		valid |-> !$isunknown({lane, res_sel, imm_form}) &&
			(res_sel == RES_ZERO || res_sel == RES_INT || res_sel == RES_FP));

endmodule : cond_reg_update

`default_nettype wire

// File: hw/cmp_unit.sv
// Top level of the compare unit, to be placed in the execute stage with its condition register
`default_nettype none

module cmp_unit
	import cmp_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              issue,
	input  logic [INSN_W-1:0] ir,
	input  logic [MODE_W-1:0] om,
	input  logic [DATA_W-1:0] a,
	input  logic [DATA_W-1:0] b,
	input  logic [DATA_W-1:0] imm,
	output logic [DATA_W-1:0] cr,
	output logic              done
);

	// Stage register outputs
	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] op_b;
	logic              is_signed;
	res_sel_t          res_sel;
	logic              imm_form;
	logic [MODE_W-1:0] lane;
	logic              valid;

	// Comparator flags
	logic int_eq;
	logic int_lt;
	logic int_le;
	logic int_ca;
	logic int_nand;
	logic int_nor;
	logic fp_eq;
	logic fp_lt;
	logic fp_le;
	logic fp_inf;
	logic fp_nan;

	// ======================================================================
	// Decode and stage register
	// ======================================================================

	cmp_decode u_decode (
		.clk       (clk),
		.rst       (rst),
		.issue     (issue),
		.ir        (ir),
		.om        (om),
		.a         (a),
		.b         (b),
		.imm       (imm),
		.op_a      (op_a),
		.op_b      (op_b),
		.is_signed (is_signed),
		.res_sel   (res_sel),
		.imm_form  (imm_form),
		.lane      (lane),
		.valid     (valid)
	);

	// ======================================================================
	// Comparators
	// ======================================================================

	int_compare u_int_cmp (
		.op_a      (op_a),
		.op_b      (op_b),
		.is_signed (is_signed),
		.eq        (int_eq),
		.lt        (int_lt),
		.le        (int_le),
		.ca        (int_ca),
		.nand_f    (int_nand),
		.nor_f     (int_nor)
	);

	fp_compare u_fp_cmp (
		.op_a (op_a),
		.op_b (op_b),
		.eq   (fp_eq),
		.lt   (fp_lt),
		.le   (fp_le),
		.inf  (fp_inf),
		.nan  (fp_nan)
	);

	// Condition register merge
	cond_reg_update u_cr (
		.clk      (clk),
		.rst      (rst),
		.valid    (valid),
		.lane     (lane),
		.res_sel  (res_sel),
		.imm_form (imm_form),
		.int_eq   (int_eq),
		.int_lt   (int_lt),
		.int_le   (int_le),
		.int_ca   (int_ca),
		.int_nand (int_nand),
		.int_nor  (int_nor),
		.fp_eq    (fp_eq),
		.fp_lt    (fp_lt),
		.fp_le    (fp_le),
		.fp_inf   (fp_inf),
		.fp_nan   (fp_nan),
		.cr       (cr),
		.done     (done)
	);

endmodule : cmp_unit

`default_nettype wire

// File: dv/cmp_unit_tb.sv
// Self-checking testbench that plays the compare vector file against the compare unit top level
`default_nettype none

module cmp_unit_tb
	import cmp_pkg::*;
();

	logic              clk;
	logic              rst;
	logic              issue;
	logic [INSN_W-1:0] ir;
	logic [MODE_W-1:0] om;
	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] b;
	logic [DATA_W-1:0] imm;
	logic [DATA_W-1:0] cr;
	logic              done;

	// Vectors as read from the data file, one entry per compare
	string             vec_name[$];
	logic [INSN_W-1:0] vec_ir[$];
	logic [MODE_W-1:0] vec_om[$];
	logic [DATA_W-1:0] vec_a[$];
	logic [DATA_W-1:0] vec_b[$];
	logic [DATA_W-1:0] vec_imm[$];
	logic [DATA_W-1:0] vec_cr[$];

	// Compares in flight, oldest first, with the cycle they were driven in
	string             pend_name[$];
	logic [DATA_W-1:0] pend_cr[$];
	int                pend_cyc[$];

	int cycle_cnt = 0;
	int limit     = 0;
	int pass_cnt  = 0;
	int fail_cnt  = 0;
	int err_cnt   = 0;
	bit loaded    = 1'b0;

	cmp_unit i_cmp_unit (
		.clk   (clk),
		.rst   (rst),
		.issue (issue),
		.ir    (ir),
		.om    (om),
		.a     (a),
		.b     (b),
		.imm   (imm),
		.cr    (cr),
		.done  (done)
	);

	// ======================================================================
	// Clock, cycle count and watchdog
	// ======================================================================

	initial
		clk = 1'b0;
	always #50 clk = ~clk;

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	// Two edges per compare plus margin for reset and the final drain
	initial
	begin
		wait (loaded);
		while (cycle_cnt < limit)
			@(posedge clk);
		$display("Timeout after %0d cycles with %0d compares still waiting for done",
			cycle_cnt, pend_cr.size());
		$display(">>> FAIL");
		$finish;
	end

	// ======================================================================
	// Helpers
	// ======================================================================

	// Lines that do not hold all seven fields are comments or blank
	task automatic load_vectors();
		int          fd;
		int          code;
		string       line;
		string       name;
		logic [31:0] f_ir;
		logic [31:0] f_om;
		logic [31:0] f_a;
		logic [31:0] f_b;
		logic [31:0] f_imm;
		logic [31:0] f_cr;
		fd = $fopen("dv/cmp_unit_vectors.txt", "r");
		if (fd == 0)
			return;
		while (!$feof(fd))
		begin
			line = "";
			code = $fgets(line, fd);
			code = $sscanf(line, "%s %h %h %h %h %h %h", name, f_ir, f_om, f_a, f_b, f_imm, f_cr);
			if (code == 7)
			begin
				vec_name.push_back(name);
				vec_ir.push_back(f_ir[INSN_W-1:0]);
				vec_om.push_back(f_om[MODE_W-1:0]);
				vec_a.push_back(f_a[DATA_W-1:0]);
				vec_b.push_back(f_b[DATA_W-1:0]);
				vec_imm.push_back(f_imm[DATA_W-1:0]);
				vec_cr.push_back(f_cr[DATA_W-1:0]);
			end
		end
		$fclose(fd);
	endtask

	// Called on every falling edge, where cr and done have settled
	task automatic service_done();
		string             name;
		logic [DATA_W-1:0] exp_cr;
		int                drv_cyc;
		if (done !== 1'b1)
			return;
		if (pend_cr.size() == 0)
		begin
			$display("Error: done pulsed in cycle %0d with no compare outstanding", cycle_cnt);
			err_cnt++;
			return;
		end
		name    = pend_name.pop_front();
		exp_cr  = pend_cr.pop_front();
		drv_cyc = pend_cyc.pop_front();
		// Driven before edge N, staged at N, merged at N+1
		if (cycle_cnt - drv_cyc != 2)
		begin
			$display("FAIL %s latency expected 2 actual %0d", name, cycle_cnt - drv_cyc);
			fail_cnt++;
		end
		else if (cr !== exp_cr)
		begin
			$display("FAIL %s expected %08h actual %08h", name, exp_cr, cr);
			fail_cnt++;
		end
		else
		begin
			$display("ok   %s cr=%08h", name, cr);
			pass_cnt++;
		end
	endtask

	task automatic drive_vector(input int idx);
		issue = 1'b1;
		ir    = vec_ir[idx];
		om    = vec_om[idx];
		a     = vec_a[idx];
		b     = vec_b[idx];
		imm   = vec_imm[idx];
		pend_name.push_back(vec_name[idx]);
		pend_cr.push_back(vec_cr[idx]);
		pend_cyc.push_back(cycle_cnt);
	endtask

	task automatic check_reset();
		if (cr !== '0 || done !== 1'b0)
		begin
			$display("FAIL reset_state expected cr=%08h done=0 actual cr=%08h done=%b",
				32'h0, cr, done);
			fail_cnt++;
		end
		else
		begin
			$display("ok   reset_state cr=%08h", cr);
			pass_cnt++;
		end
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================

	initial
	begin
		rst   = 1'b1;
		issue = 1'b0;
		ir    = '0;
		om    = '0;
		a     = '0;
		b     = '0;
		imm   = '0;
		load_vectors();
		limit  = vec_cr.size() * 2 + 20;
		loaded = 1'b1;
		if (vec_cr.size() == 0)
		begin
			$display("Error: no vectors could be read from dv/cmp_unit_vectors.txt");
			$display(">>> FAIL");
			$finish;
		end
		else
		begin
			// Reset spans three rising edges
			repeat (3) @(posedge clk);
			@(negedge clk);
			rst = 1'b0;
			check_reset();
			// One compare per cycle, so two are always in flight
			for (int i = 0; i < vec_cr.size(); i++)
			begin
				@(negedge clk);
				service_done();
				drive_vector(i);
			end
			@(negedge clk);
			service_done();
			issue = 1'b0;
			while (pend_cr.size() > 0)
			begin
				@(negedge clk);
				service_done();
			end
			// A few idle cycles catch a stray done
			repeat (3)
			begin
				@(negedge clk);
				service_done();
			end
			$display("Tests: %0d passed, %0d failed, %0d other errors",
				pass_cnt, fail_cnt, err_cnt);
			if (fail_cnt == 0 && err_cnt == 0)
				$display(">>> PASS");
			else
				$display(">>> FAIL");
			$finish;
		end
	end

endmodule : cmp_unit_tb

`default_nettype wire

// File: dv/cmp_unit_vectors.txt
# Columns: name ir om a b imm expected_cr, all numbers in hex
# expected_cr is the whole condition register after that compare, in file order
# Signed and unsigned forms of the same operands, one per lane
s_m1_vs_1        0000000c 0 ffffffff 00000001 00000000 00000018  # lt le
u_m1_vs_1        0000008c 1 ffffffff 00000001 00000000 00000018  # all clear
s_1_vs_m1        0000000c 2 00000001 ffffffff 00000000 00200018  # carry only
u_1_vs_m1        0000008c 3 00000001 ffffffff 00000000 38200018  # lt le ca
eq_zero_zero     0000000c 1 00000000 00000000 00000000 38201718  # eq nand nor le
nand_disjoint    0000008c 0 f0f0f0f0 0f0f0f0f 00000000 38201702  # nand only
# Reserved bit set by a NaN, then kept by imm form and cleared by reg form
fp_nan_reg       0000010c 2 7fc00000 3f800000 00000000 38c01702  # so resv
imm_keeps_resv   8000000c 2 00000005 deadbeef 00000005 38d11702  # eq le so resv
reg_clears_resv  0000000c 2 00000005 00000007 00000005 38781702  # lt le ca so
imm_cmpa         8000008c 3 00000010 00000000 00000020 3a781702  # uses imm
# FP ordering, zeros and infinities
fp_lt_pos        0000010c 0 3f800000 40000000 00000000 3a78171a  # 1.0 < 2.0
fp_neg_order     0000010c 0 c0000000 bf800000 00000000 3a781718  # -2.0 < -1.0
fp_zeros         0000010c 1 80000000 00000000 00000000 3a781318  # -0 == +0
fp_pos_gt_neg    0000010c 1 3f800000 bf800000 00000000 3a780018  # 1.0 > -1.0
fp_inf           0000010c 3 7f800000 3f800000 00000000 20780018  # inf sets ca
fp_neg_inf_imm   8000010c 3 ff800000 7fc00000 00000000 3a780018  # -inf < 0
fp_nan_imm       8000010c 1 3f800000 00000000 7f800001 3a784018  # so, resv kept
# Summary overflow stays set through later integer compares
so_sticky_int    0000000c 1 00000003 00000003 00000000 3a785118  # eq le so
fp_nan_lane0     0000010c 0 00000000 ffc00000 00000000 3a7851c2  # nand so resv
so_sticky_cmpa   0000008c 0 00000000 00000000 00000000 3a785157  # so kept resv cleared
# Invalid forms write a zero byte
bad_op2          0000018c 2 00000001 00000002 00000000 3a005157  # op2 code 3
non_cmp_opcode   00000033 3 00000001 00000001 00000000 00005157  # not a compare
# Refill lanes after the zero writes
s_min_imm        8000000c 3 80000000 00000000 00000001 1a005157  # most negative < 1
s_eq_neg         0000000c 2 fffffffe fffffffe 00000000 1a115157  # eq le
fp_opp_sign      0000010c 1 40490fdb c0490fdb 00000000 1a114057  # so sticky in fp
fp_denorm        0000010c 2 00000001 00000002 00000000 1a1a4057  # subnormal order

// File: cmp_unit.f
hw/cmp_pkg.sv
hw/cmp_decode.sv
hw/int_compare.sv
hw/fp_compare.sv
hw/cond_reg_update.sv
hw/cmp_unit.sv
dv/cmp_unit_tb.sv

// File: Bender.yml
package:
  name: cmp_unit

sources:
  # Package first, then leaf modules, then the top level
  - files:
      - hw/cmp_pkg.sv
      - hw/cmp_decode.sv
      - hw/int_compare.sv
      - hw/fp_compare.sv
      - hw/cond_reg_update.sv
      - hw/cmp_unit.sv
  - target: test
    files:
      - dv/cmp_unit_tb.sv
